/* verilog.f */
cpc_glue_pkg.sv
rom_loader.sv
mf2_trap.sv
mf2_store.sv
mem_request_mux.sv
cpc_glue_top.sv
tb_cpc_glue.sv

/* Makefile */
# Verilator simulation of the CPC glue testbench

VERILATOR ?= verilator
TOP       ?= tb_cpc_glue
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= V$(TOP)
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* tb_cpc_glue.sv */
// Self-checking testbench for the CPC glue top level; built from verilog.f and run by the Makefile
`default_nettype none

module tb_cpc_glue;
	timeunit 1ns;
	timeprecision 1ps;

	import cpc_glue_pkg::*;

	localparam int CLK_PERIOD      = 10;
	localparam int TOTAL_BYTES     = 96;
	localparam int CYCLES_PER_BYTE = 48;
	localparam int OTHER_CYCLES    = 2000;
	localparam int TIMEOUT_NS      = (TOTAL_BYTES * CYCLES_PER_BYTE + OTHER_CYCLES) * CLK_PERIOD;

	typedef struct packed {
		bank_t     bank;
		mem_addr_t addr;
		byte_t     data;
	} wr_rec_t;

	logic      clk_sys;
	logic      reset;
	dl_bus_t   dl;
	cpu_bus_t  cpu;
	logic      key_nmi;
	mf2_mode_t mf2_mode;
	byte_t     mem_dout;
	mem_req_t  mem_req;
	byte_t     cpu_din;
	logic      nmi;
	logic      dl_wait;
	logic      loading;
	rom_map_t  rom_map;

	byte_t       mem_model [logic [23:0]];
	wr_rec_t     exp_q [$];
	wr_rec_t     exp_log [$];
	wr_rec_t     exp_wr;
	wr_rec_t     last_rec;
	rom_map_t    exp_map;
	logic [31:0] rng_state;
	logic [31:0] r;
	logic        prev_we;
	logic        we_rise;
	byte_t       mode_val;
	byte_t       crtc_val;
	cpu_addr_t   caddr;

	cpc_glue_top #(.REF_DIV_LOG2(3)) dut_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl       (dl),
		.cpu      (cpu),
		.key_nmi  (key_nmi),
		.mf2_mode (mf2_mode),
		.mem_dout (mem_dout),
		.mem_req  (mem_req),
		.cpu_din  (cpu_din),
		.nmi      (nmi),
		.dl_wait  (dl_wait),
		.loading  (loading),
		.rom_map  (rom_map)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish in the expected time");
		$display("=== FAIL ===");
		$fatal(1, "Watchdog expired");
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// {valid, nibble} for one extension character
	function automatic logic [4:0] hex_value(input byte_t c);
		byte_t d;
		d = 8'h00;
		if (c >= "0" && c <= "9") begin
			d = c - "0";
			return {1'b1, d[3:0]};
		end
		if (c >= "A" && c <= "F") begin
			d = c - "A" + 8'd10;
			return {1'b1, d[3:0]};
		end
		return 5'd0;
	endfunction

	function automatic logic [8:0] ext_base(input logic [15:0] ext, input logic [24:0] addr);
		logic [4:0] hi;
		logic [4:0] lo;
		hi = hex_value(ext[15:8]);
		lo = hex_value(ext[7:0]);
		// Combo image, second part lands after the Multiface page
		if (ext == "Z0")
			return (addr[24:14] == 11'd0) ? 9'h000 : 9'h1FF;
		if (ext == "ZZ")
			return 9'h000;
		if (hi[4] && lo[4])
			return {1'b1, hi[3:0], lo[3:0]};
		return 9'h1EE;
	endfunction

	// {first bank, page} for one download byte
	function automatic logic [9:0] ref_target(input logic [7:0] index, input logic [15:0] ext,
		input logic [24:0] addr);
		logic [8:0] base;
		logic [8:0] page;
		if (index == 8'd0) begin
			// Four system images, repeated for bank 1
			case (addr[15:14])
				2'd0: page = 9'h000;
				2'd1: page = 9'h100;
				2'd2: page = 9'h107;
				default: page = 9'h1FF;
			endcase
			return {addr[16], page};
		end
		base = ext_base(ext, addr);
		page = {base[8], base[7:0] + addr[21:14]};
		return {1'b0, page};
	endfunction

	function automatic byte_t read_model(input logic [23:0] key);
		return mem_model.exists(key) ? mem_model[key] : 8'hFF;
	endfunction

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "Check failed");
		end
	endtask

	task automatic next_random(output logic [31:0] value);
		rng_state = xorshift32(rng_state);
		value = rng_state;
	endtask

	////////////////////////////////////////////////////////////
	// Memory model and write comparator
	////////////////////////////////////////////////////////////

	always @(posedge clk_sys) begin
		mem_dout <= mem_req.oe ? read_model({mem_req.bank[0], mem_req.addr}) : 8'hFF;
	end

	always @(negedge clk_sys) begin
		if (mem_req.we)
			mem_model[{mem_req.bank[0], mem_req.addr}] = mem_req.din;
	end

	always @(negedge clk_sys) begin
		we_rise = mem_req.we && !prev_we;
		prev_we = mem_req.we;
		if (we_rise && exp_q.size() == 0) begin
			$display("Memory write to address 0x%0h when no write was expected", mem_req.addr);
			$display("=== FAIL ===");
			$fatal(1, "Unexpected write");
		end else if (we_rise) begin
			exp_wr = exp_q.pop_front();
			check("write bank", 32'(exp_wr.bank), 32'(mem_req.bank));
			check("write address", 32'(exp_wr.addr), 32'(mem_req.addr));
			check("write data", 32'(exp_wr.data), 32'(mem_req.din));
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////

	task automatic apply_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		exp_map = '0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic send_byte(input logic [24:0] addr, input byte_t data);
		@(posedge clk_sys);
		dl.addr <= addr;
		dl.data <= data;
		dl.wr   <= 1'b1;
		@(posedge clk_sys);
		dl.wr <= 1'b0;
		@(negedge clk_sys);
		check("dl_wait raised", 32'd1, 32'(dl_wait));
		while (dl_wait)
			@(negedge clk_sys);
		check("loading held", 32'd1, 32'(loading));
	endtask

	task automatic download_rom(input logic [7:0] index, input logic [15:0] ext, input int blocks);
		logic [24:0] addr;
		logic [13:0] offset;
		logic [9:0]  target;
		wr_rec_t     rec;
		exp_log.delete();
		@(posedge clk_sys);
		dl.download <= 1'b1;
		dl.index    <= index;
		dl.file_ext <= ext;
		repeat (2) @(posedge clk_sys);
		for (int b = 0; b < blocks; b++) begin
			for (int i = 0; i < 8; i++) begin
				next_random(r);
				// Distinct offsets, last one ends the block
				offset   = (i == 7) ? 14'h3FFF : {i[2:0], r[10:0]};
				addr     = {11'(b), offset};
				target   = ref_target(index, ext, addr);
				rec.addr = {target[8:0], offset};
				rec.data = r[31:24];
				rec.bank = {1'b0, target[9]};
				exp_q.push_back(rec);
				exp_log.push_back(rec);
				if (index != 8'd0) begin
					rec.bank = 2'd1;
					exp_q.push_back(rec);
					exp_log.push_back(rec);
				end
				if (target[8])
					exp_map[target[7:0]] = 1'b1;
				send_byte(addr, rec.data);
			end
		end
		@(posedge clk_sys);
		dl.download <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check("pending writes", 32'd0, 32'(exp_q.size()));
		foreach (exp_log[k])
			check("readback", 32'(exp_log[k].data),
				32'(read_model({exp_log[k].bank[0], exp_log[k].addr})));
		for (int w = 0; w < 8; w++)
			check("rom_map", exp_map[w*32 +: 32], rom_map[w*32 +: 32]);
		last_rec = exp_log[exp_log.size() - 1];
	endtask

	task automatic cpu_read(input cpu_addr_t ca, input mem_addr_t ma);
		@(posedge clk_sys);
		cpu.cpu_addr <= ca;
		cpu.mem_addr <= ma;
		cpu.mem_rd   <= 1'b1;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic io_write(input cpu_addr_t port, input byte_t data);
		@(posedge clk_sys);
		cpu.mem_rd   <= 1'b0;
		cpu.cpu_addr <= port;
		cpu.dout     <= data;
		cpu.io_wr    <= 1'b1;
		repeat (2) @(posedge clk_sys);
		cpu.io_wr <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic fetch(input cpu_addr_t ca);
		@(posedge clk_sys);
		cpu.mem_rd   <= 1'b0;
		cpu.cpu_addr <= ca;
		cpu.m1       <= 1'b1;
		repeat (2) @(posedge clk_sys);
		cpu.m1 <= 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic press_key();
		@(posedge clk_sys);
		key_nmi <= 1'b1;
		repeat (2) @(posedge clk_sys);
		key_nmi <= 1'b0;
		@(negedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		reset      <= 1'b1;
		dl         <= '0;
		cpu        <= '0;
		key_nmi    <= 1'b0;
		mf2_mode   <= MF2_ENABLED;
		mem_dout   <= 8'hFF;
		rng_state  = 32'd12;
		prev_we    = 1'b0;
		exp_map    = '0;
		apply_reset();

		// Empty map blocks upper ROM reads
		cpu_read(16'h4000, {1'b1, 8'h20, 14'h0100});
		check("unmapped oe", 32'd0, 32'(mem_req.oe));

		download_rom(8'd0, 16'h0000, 8);
		apply_reset();
		download_rom(8'd3, "0C", 2);
		download_rom(8'd3, "Z0", 2);

		// Page written by the combo image reads back
		cpu.bank_sel <= last_rec.bank[0];
		cpu_read(16'h4000, last_rec.addr);
		check("mapped oe", 32'd1, 32'(mem_req.oe));
		check("mapped data", 32'(last_rec.data), 32'(cpu_din));
		@(posedge clk_sys);
		cpu.mem_rd <= 1'b0;
		@(negedge clk_sys);
		check("mapped oe idle", 32'd0, 32'(mem_req.oe));

		// Shadow stores, then the trap
		next_random(r);
		mode_val = 8'h80 | (r[7:0] & 8'h0F);
		crtc_val = r[15:8];
		io_write(16'h7F00, mode_val);
		io_write(16'hBC00, 8'd5);
		io_write(16'hBD00, crtc_val);
		press_key();
		check("nmi raised", 32'd1, 32'(nmi));
		fetch(16'h0066);
		check("nmi cleared", 32'd0, 32'(nmi));
		repeat (4) begin
			next_random(r);
			caddr = {3'b000, r[12:0]};
			cpu_read(caddr, {1'b0, 8'h02, caddr[13:0]});
			check("mf2 rom page", 32'h1FF, 32'(mem_req.addr[22:14]));
			check("mf2 rom offset", 32'(caddr[13:0]), 32'(mem_req.addr[13:0]));
		end
		cpu_read(16'h3FEF, {1'b0, 8'h00, 14'h1FEF});
		check("shadow mode", 32'(mode_val), 32'(cpu_din));
		cpu_read(16'h3DB5, {1'b0, 8'h00, 14'h1DB5});
		check("shadow crtc", 32'(crtc_val), 32'(cpu_din));

		// Port paging and the hide flag
		io_write(16'hFEEA, 8'h00);
		cpu_read(16'h0100, {1'b0, 8'h03, 14'h0100});
		check("paged out addr", 32'({1'b0, 8'h03, 14'h0100}), 32'(mem_req.addr));
		check("paged out oe", 32'd1, 32'(mem_req.oe));
		io_write(16'hFEE8, 8'h00);
		cpu_read(16'h0100, {1'b0, 8'h03, 14'h0100});
		check("paged in page", 32'h1FF, 32'(mem_req.addr[22:14]));
		fetch(16'h0065);
		io_write(16'hFEEA, 8'h00);
		io_write(16'hFEE8, 8'h00);
		cpu_read(16'h0100, {1'b0, 8'h03, 14'h0100});
		check("hidden addr", 32'({1'b0, 8'h03, 14'h0100}), 32'(mem_req.addr));

		// Disabled Multiface ignores the key
		@(posedge clk_sys);
		mf2_mode <= MF2_DISABLED;
		apply_reset();
		press_key();
		repeat (8) begin
			@(negedge clk_sys);
			check("nmi disabled", 32'd0, 32'(nmi));
		end

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* cpc_glue_top.sv */
// System glue top level; reference enable, loading reset, ROM loader, Multiface and memory routing
`default_nettype none

module cpc_glue_top #(
	parameter int REF_DIV_LOG2 = 3
) (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  cpc_glue_pkg::dl_bus_t   dl,
	input  cpc_glue_pkg::cpu_bus_t  cpu,
	input  wire                     key_nmi,
	input  cpc_glue_pkg::mf2_mode_t mf2_mode,
	input  cpc_glue_pkg::byte_t     mem_dout,
	output cpc_glue_pkg::mem_req_t  mem_req,
	output cpc_glue_pkg::byte_t     cpu_din,
	output logic                    nmi,
	output logic                    dl_wait,
	output logic                    loading,
	output cpc_glue_pkg::rom_map_t  rom_map
);

	import cpc_glue_pkg::*;

	logic [REF_DIV_LOG2-1:0] ref_div;
	logic                    ce_ref;
	logic                    mf2_en;
	logic                    ram_window;
	logic                    boot_wr;
	mem_addr_t               boot_addr;
	bank_t                   boot_bank;
	byte_t                   boot_data;
	byte_t                   mf2_dout;

	////////////////////////////////////////////////////////////
	// Reference enable and loading reset
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ref_div <= '0;
			ce_ref  <= 1'b0;
		end else begin
			ref_div <= ref_div + 1'b1;
			ce_ref  <= ref_div == '0;
		end
	end

	// CPU side held in reset while a ROM is downloading
	always_ff @(posedge clk_sys) begin
		loading <= reset | (dl.download & (dl.index < 8'd4));
	end

	////////////////////////////////////////////////////////////
	// Instances
	////////////////////////////////////////////////////////////

	rom_loader rom_loader_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ce_ref    (ce_ref),
		.dl        (dl),
		.dl_wait   (dl_wait),
		.boot_wr   (boot_wr),
		.boot_addr (boot_addr),
		.boot_bank (boot_bank),
		.boot_data (boot_data),
		.rom_map   (rom_map)
	);

	mf2_trap mf2_trap_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu      (cpu),
		.key_nmi  (key_nmi),
		.mf2_mode (mf2_mode),
		.nmi      (nmi),
		.mf2_en   (mf2_en)
	);

	mf2_store mf2_store_i (
		.clk_sys    (clk_sys),
		.cpu        (cpu),
		.mf2_en     (mf2_en),
		.mf2_dout   (mf2_dout),
		.ram_window (ram_window)
	);

	mem_request_mux mem_request_mux_i (
		.clk_sys    (clk_sys),
		.loading    (loading),
		.cpu        (cpu),
		.mf2_en     (mf2_en),
		.ram_window (ram_window),
		.mf2_mode   (mf2_mode),
		.boot_wr    (boot_wr),
		.boot_addr  (boot_addr),
		.boot_bank  (boot_bank),
		.boot_data  (boot_data),
		.rom_map    (rom_map),
		.mem_dout   (mem_dout),
		.mf2_dout   (mf2_dout),
		.mem_req    (mem_req),
		.cpu_din    (cpu_din)
	);

endmodule

`default_nettype wire

/* mem_request_mux.sv */
// Memory request routing between loader and CPU, with ROM masking, Multiface mapping and read merge
`default_nettype none

module mem_request_mux (
	input  wire                     clk_sys,
	input  wire                     loading,
	input  cpc_glue_pkg::cpu_bus_t  cpu,
	input  wire                     mf2_en,
	input  wire                     ram_window,
	input  cpc_glue_pkg::mf2_mode_t mf2_mode,
	input  wire                     boot_wr,
	input  cpc_glue_pkg::mem_addr_t boot_addr,
	input  cpc_glue_pkg::bank_t     boot_bank,
	input  cpc_glue_pkg::byte_t     boot_data,
	input  cpc_glue_pkg::rom_map_t  rom_map,
	input  cpc_glue_pkg::byte_t     mem_dout,
	input  cpc_glue_pkg::byte_t     mf2_dout,
	output cpc_glue_pkg::mem_req_t  mem_req,
	output cpc_glue_pkg::byte_t     cpu_din
);

	import cpc_glue_pkg::*;

	rom_page_t map_addr;
	logic      rom_mask;
	logic      rom_window;

	// Map lookup one cycle behind the address
	always_ff @(posedge clk_sys) begin
		map_addr <= cpu.mem_addr[21:14];
	end

	assign rom_mask = cpu.mem_addr[22] &
		(~rom_map[map_addr] | (&map_addr & (mf2_mode == MF2_DISABLED)));

	// Multiface ROM sits in the bottom 8 KB while paged in
	assign rom_window = mf2_en && cpu.cpu_addr[15:13] == 3'b000;

	always_comb begin
		if (loading) begin
			mem_req.oe   = 1'b0;
			mem_req.we   = boot_wr;
			mem_req.addr = boot_addr;
			mem_req.bank = boot_bank;
			mem_req.din  = boot_data;
		end else begin
			mem_req.oe   = cpu.mem_rd & ~ram_window & ~rom_mask;
			mem_req.we   = cpu.mem_wr & ~ram_window & ~rom_window;
			mem_req.addr = rom_window ? {MF2_ROM_PAGE, cpu.cpu_addr[13:0]} : cpu.mem_addr;
			mem_req.bank = {1'b0, cpu.bank_sel};
			mem_req.din  = cpu.dout;
		end
	end

	assign cpu_din = mem_dout & mf2_dout;

	a_oe_we: assert property (@(posedge clk_sys) !(mem_req.oe && mem_req.we));

endmodule

`default_nettype wire

/* mf2_store.sv */
// Multiface 8 KB RAM; shadows hardware register writes and serves normal CPU access in its window
`default_nettype none

module mf2_store (
	input  wire                    clk_sys,
	input  cpc_glue_pkg::cpu_bus_t cpu,
	input  wire                    mf2_en,
	output cpc_glue_pkg::byte_t    mf2_dout,
	output logic                   ram_window
);

	import cpc_glue_pkg::*;

	byte_t     ram [8192];
	mf2_addr_t store_addr;
	mf2_addr_t ram_addr;
	byte_t     ram_in;
	byte_t     ram_out;
	logic      ram_we;
	logic      old_io_wr;
	logic      io_wr_rise;
	logic      store_hit;
	logic [4:0] pen_index;
	logic [3:0] crtc_reg;

	assign ram_window = mf2_en && cpu.cpu_addr[15:13] == 3'b001;
	assign io_wr_rise = ~old_io_wr & cpu.io_wr;

	////////////////////////////////////////////////////////////
	// Shadow address decode
	////////////////////////////////////////////////////////////

	always_comb begin
		store_addr = '0;
		case (cpu.cpu_addr[15:8])
			8'h7F: begin
				// Gate array, function in data bits 7..6
				case (cpu.dout[7:6])
					2'b00: store_addr = 13'h1FCF;
					2'b01: store_addr = pen_index[4] ? 13'h1FDF : {9'h1F9, pen_index[3:0]};
					2'b10: store_addr = 13'h1FEF;
					default: store_addr = 13'h1FFF;
				endcase
			end
			8'hBC: store_addr = 13'h1CFF;
			8'hBD: store_addr = {9'h1DB, crtc_reg};
			8'hF7: store_addr = 13'h17FF;
			8'hDF: store_addr = 13'h1AAC;
			default: store_addr = '0;
		endcase
	end

	assign store_hit = |store_addr;

	////////////////////////////////////////////////////////////
	// RAM port
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		old_io_wr <= cpu.io_wr;
		if (io_wr_rise && store_hit) begin
			// Keep selectors for later pen and CRTC value writes
			if (cpu.cpu_addr[15:8] == 8'h7F && cpu.dout[7:6] == 2'b00)
				pen_index <= cpu.dout[4:0];
			if (cpu.cpu_addr[15:8] == 8'hBC)
				crtc_reg <= cpu.dout[3:0];
			ram_addr <= store_addr;
			ram_in   <= cpu.dout;
			ram_we   <= 1'b1;
		end else if (cpu.mem_wr && ram_window) begin
			ram_addr <= cpu.mem_addr[12:0];
			ram_in   <= cpu.dout;
			ram_we   <= 1'b1;
		end else begin
			ram_addr <= cpu.mem_addr[12:0];
			ram_we   <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_addr] <= ram_in;
			ram_out       <= ram_in;
		end else begin
			ram_out <= ram[ram_addr];
		end
	end

	// Pulled high when idle, merged by AND on the CPU side
	assign mf2_dout = (ram_window && cpu.mem_rd) ? ram_out : 8'hFF;

endmodule

`default_nettype wire

/* mf2_trap.sv */
// Multiface 2 trap logic; NMI request on key press, entry at 0x0066, hide flag and port paging
`default_nettype none

module mf2_trap (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  cpc_glue_pkg::cpu_bus_t  cpu,
	input  wire                     key_nmi,
	input  cpc_glue_pkg::mf2_mode_t mf2_mode,
	output logic                    nmi,
	output logic                    mf2_en
);

	import cpc_glue_pkg::*;

	localparam cpu_addr_t NMI_ENTRY = 16'h0066;
	localparam cpu_addr_t HIDE_ADDR = 16'h0065;

	logic mf2_hidden;
	logic old_key_nmi;
	logic old_m1;
	logic old_io_wr;
	logic key_rise;
	logic m1_rise;
	logic io_wr_rise;
	logic page_port;

	assign key_rise   = ~old_key_nmi & key_nmi;
	assign m1_rise    = ~old_m1 & cpu.m1;
	assign io_wr_rise = ~old_io_wr & cpu.io_wr;

	// 0xFEE8 enables, 0xFEEA disables
	assign page_port  = cpu.cpu_addr[15:2] == 14'b11111110111010;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nmi         <= 1'b0;
			mf2_en      <= 1'b0;
			mf2_hidden  <= mf2_mode != MF2_ENABLED;
			old_key_nmi <= 1'b0;
			old_m1      <= 1'b0;
			old_io_wr   <= 1'b0;
		end else begin
			old_key_nmi <= key_nmi;
			old_m1      <= cpu.m1;
			old_io_wr   <= cpu.io_wr;

			if (key_rise && !mf2_en && mf2_mode != MF2_DISABLED)
				nmi <= 1'b1;

			// NMI vector fetch pages the Multiface in
			if (nmi && m1_rise && cpu.cpu_addr == NMI_ENTRY) begin
				mf2_en     <= 1'b1;
				mf2_hidden <= 1'b0;
				nmi        <= 1'b0;
			end

			if (mf2_en && m1_rise && cpu.cpu_addr == HIDE_ADDR)
				mf2_hidden <= 1'b1;

			if (io_wr_rise && page_port) begin
				mf2_en <= ~cpu.cpu_addr[1] & ~mf2_hidden;
				// A pending request is served once paged in
				if (!cpu.cpu_addr[1] && !mf2_hidden)
					nmi <= 1'b0;
			end
		end
	end

	a_nmi_vs_en: assert property (@(posedge clk_sys) disable iff (reset)
		!(nmi && mf2_en));

endmodule

`default_nettype wire

/* rom_loader.sv */
// ROM download decoder; turns download bytes into ce_ref-timed memory writes and keeps the ROM map
`default_nettype none

module rom_loader (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     ce_ref,
	input  cpc_glue_pkg::dl_bus_t   dl,
	output logic                    dl_wait,
	output logic                    boot_wr,
	output cpc_glue_pkg::mem_addr_t boot_addr,
	output cpc_glue_pkg::bank_t     boot_bank,
	output cpc_glue_pkg::byte_t     boot_data,
	output cpc_glue_pkg::rom_map_t  rom_map
);

	import cpc_glue_pkg::*;

	typedef enum logic [1:0] {
		LD_IDLE,
		LD_WAIT,
		LD_WRITE
	} ld_state_t;

	ld_state_t  state;
	logic [8:0] page_base;
	logic       combo;
	logic       two_banks;
	logic       old_download;
	logic       rom_download;
	logic       dl_start;
	logic [4:0] ext_hi;
	logic [4:0] ext_lo;

	// {valid, value} for one ASCII hex digit
	function automatic logic [4:0] hex_digit(input byte_t c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	assign rom_download = dl.download && (dl.index < 8'd4);
	assign dl_start     = ~old_download & rom_download;
	assign ext_hi       = hex_digit(dl.file_ext[15:8]);
	assign ext_lo       = hex_digit(dl.file_ext[7:0]);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state        <= LD_IDLE;
			dl_wait      <= 1'b0;
			boot_wr      <= 1'b0;
			rom_map      <= '0;
			page_base    <= 9'h1EE;
			combo        <= 1'b0;
			two_banks    <= 1'b0;
			old_download <= 1'b0;
		end else begin
			old_download <= dl.download;

			// Page base from the extension, taken once per download
			if (dl_start && dl.index != 8'd0) begin
				page_base <= 9'h1EE;
				combo     <= 1'b0;
				if (ext_hi[4] && ext_lo[4])
					page_base[7:0] <= {ext_hi[3:0], ext_lo[3:0]};
				if (dl.file_ext == "ZZ")
					page_base <= 9'h000;
				if (dl.file_ext == "Z0") begin
					page_base <= 9'h000;
					combo     <= 1'b1;
				end
			end

			case (state)
				LD_IDLE: begin
					if (rom_download && dl.wr) begin
						boot_data       <= dl.data;
						boot_addr[13:0] <= dl.addr[13:0];
						boot_bank       <= 2'd0;
						two_banks       <= |dl.index[5:0];
						if (dl.index != 8'd0) begin
							// Expansion ROM, relative to the page base
							boot_addr[22]    <= page_base[8];
							boot_addr[21:14] <= page_base[7:0] + dl.addr[21:14];
							dl_wait          <= 1'b1;
							state            <= LD_WAIT;
						end else begin
							// System ROM blocks, 16 KB each
							dl_wait <= 1'b1;
							state   <= LD_WAIT;
							case (dl.addr[24:14])
								11'd0, 11'd4: boot_addr[22:14] <= 9'h000;
								11'd1, 11'd5: boot_addr[22:14] <= 9'h100;
								11'd2, 11'd6: boot_addr[22:14] <= 9'h107;
								11'd3, 11'd7: boot_addr[22:14] <= MF2_ROM_PAGE;
								default: begin
									dl_wait <= 1'b0;
									state   <= LD_IDLE;
								end
							endcase
							if (dl.addr[24:14] >= 11'd4)
								boot_bank <= 2'd1;
						end
					end
				end

				LD_WAIT: begin
					if (ce_ref) begin
						boot_wr <= 1'b1;
						state   <= LD_WRITE;
					end
				end

				LD_WRITE: begin
					if (ce_ref) begin
						boot_wr <= 1'b0;
						if (two_banks && boot_bank == 2'd0) begin
							// Same byte again into bank 1
							boot_bank <= 2'd1;
							state     <= LD_WAIT;
						end else begin
							dl_wait <= 1'b0;
							state   <= LD_IDLE;
							if (boot_addr[22])
								rom_map[boot_addr[21:14]] <= 1'b1;
							// Combo image moves on after its first 16 KB
							if (combo && &boot_addr[13:0]) begin
								combo     <= 1'b0;
								page_base <= MF2_ROM_PAGE;
							end
						end
					end
				end

				default: state <= LD_IDLE;
			endcase
		end
	end

	// Writes only happen while the source is held off
	a_wr_under_wait: assert property (@(posedge clk_sys) disable iff (reset)
		boot_wr |-> dl_wait);

endmodule

`default_nettype wire

/* cpc_glue_pkg.sv */
// Shared widths, bus structs and the Multiface mode enum; imported by every glue module
`default_nettype none

package cpc_glue_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	typedef logic [7:0]   byte_t;
	typedef logic [15:0]  cpu_addr_t;

	// Bit 22 marks upper-ROM space, bits 21..14 the page
	typedef logic [22:0]  mem_addr_t;

	typedef logic [7:0]   rom_page_t;
	typedef logic [1:0]   bank_t;
	typedef logic [12:0]  mf2_addr_t;

	// One flag per upper-ROM page
	typedef logic [255:0] rom_map_t;

	////////////////////////////////////////////////////////////
	// Buses
	////////////////////////////////////////////////////////////

	// Download stream from the host side
	typedef struct packed {
		logic        download;
		logic        wr;
		logic [24:0] addr;
		byte_t       data;
		logic [7:0]  index;
		logic [15:0] file_ext;
	} dl_bus_t;

	// CPU side, mem_addr already mapped by the motherboard
	typedef struct packed {
		cpu_addr_t cpu_addr;
		mem_addr_t mem_addr;
		byte_t     dout;
		logic      m1;
		logic      mem_rd;
		logic      mem_wr;
		logic      io_wr;
		logic      bank_sel;
	} cpu_bus_t;

	// Request to external memory
	typedef struct packed {
		logic      oe;
		logic      we;
		mem_addr_t addr;
		bank_t     bank;
		byte_t     din;
	} mem_req_t;

	////////////////////////////////////////////////////////////
	// Multiface
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		MF2_ENABLED,
		MF2_HIDDEN,
		MF2_DISABLED
	} mf2_mode_t;

	// Page holding the Multiface ROM
	localparam logic [8:0] MF2_ROM_PAGE = 9'h1FF;

endpackage

`default_nettype wire
